//--- exec_config.svh
// width and latency macros for the execute stage, included by the data package, merge stage and testbench
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// data word width
// operands, immediates, results and pc values all use this width
`define EXEC_WORD_W 16

// shift and rotate count width
// the count is taken from the low bits of operand b
`define EXEC_SHAMT_W 4

// cycles from the input strobe to the output strobe
// only the merge stage holds registers
// alu and branch unit are purely combinational
`define EXEC_LATENCY 1

`endif

//--- execDataPkg.sv
// plain vector types for data moving through the execute stage, referenced by scoped name
`include "exec_config.svh"

package execDataPkg;

   // one machine word
   // used for register operands, the sign-extended immediate,
   // alu results, the incremented pc and the branch target
   typedef logic [`EXEC_WORD_W-1:0] word_t;

   // shift or rotate count
   // rol, sll, ror and srl read this many low bits of operand b
   typedef logic [`EXEC_SHAMT_W-1:0] shamt_t;

endpackage

//--- execCtlPkg.sv
// decoded control encodings handed from decode to the execute stage, referenced by scoped name

package execCtlPkg;

   // base alu operation
   // SUB is operand b minus operand a, as the processor defines it
   // ANDN is a and not b
   // rotates and shifts use the low bits of operand b as the count
   typedef enum logic [2:0] {
      ADD  = 3'b000,
      SUB  = 3'b001,
      XOR  = 3'b010,
      ANDN = 3'b011,
      ROL  = 3'b100,
      SLL  = 3'b101,
      ROR  = 3'b110,
      SRL  = 3'b111
   } aluOp_t;

   // result override applied after the base operation
   // SEQ, SLT and SLE are signed compares of a against b
   // SCO is the carry out of a plus b
   // BTR reverses a, SLBI shifts a up one byte and merges the immediate byte
   typedef enum logic [2:0] {
      NONE = 3'b000,
      SEQ  = 3'b001,
      SLT  = 3'b010,
      SLE  = 3'b011,
      SCO  = 3'b100,
      BTR  = 3'b101,
      SLBI = 3'b110
   } setKind_t;

   // condition tested on register 1
   typedef enum logic [2:0] {
      NEVER  = 3'b000,
      BEQZ   = 3'b001,
      BNEZ   = 3'b010,
      BLTZ   = 3'b011,
      BGEZ   = 3'b100,
      ALWAYS = 3'b101
   } brCond_t;

   // base that the immediate is added to
   // PC_REL uses the incremented pc, REG_REL uses register 1 (jr style)
   typedef enum logic {
      PC_REL  = 1'b0,
      REG_REL = 1'b1
   } pcSel_t;

endpackage

//--- aluUnit.sv
// combinational alu datapath of the execute stage, instantiated by executeStage beside branchUnit
`timescale 1ns/1ps

module aluUnit (
   input  execDataPkg::word_t   regData1,
   input  execDataPkg::word_t   regData2,
   input  execDataPkg::word_t   immVal,
   input  logic                 aluSrc,
   input  execCtlPkg::aluOp_t   aluOp,
   input  execCtlPkg::setKind_t setKind,
   output execDataPkg::word_t   aluResult,
   output logic                 aluZero,
   output logic                 aluOfl
);

   localparam int wordW  = $bits(execDataPkg::word_t);
   localparam int shamtW = $bits(execDataPkg::shamt_t);
   // slbi moves a up by one byte
   localparam int byteW  = 8;

   execDataPkg::word_t  opA;
   execDataPkg::word_t  opB;
   execDataPkg::word_t  subOut;
   execDataPkg::word_t  baseOut;
   execDataPkg::word_t  reversed;
   execDataPkg::shamt_t shamt;
   logic [wordW:0]      addWide;
   logic [2*wordW-1:0]  rolWide;
   logic [2*wordW-1:0]  rorWide;
   logic                addOfl;
   logic                subOfl;
   logic                cmpBit;

   // operand b is the register or the sign-extended immediate
   assign opA = regData1;
   assign opB = aluSrc ? immVal : regData2;
   assign shamt = opB[shamtW-1:0];

   // one extra bit keeps the carry for sco
   assign addWide = {1'b0, opA} + {1'b0, opB};
   // reversed operand order on subtract
   assign subOut = opB - opA;

   // rotates shift a doubled copy of a
   // upper half after a left shift, lower half after a right shift
   assign rolWide = {opA, opA} << shamt;
   assign rorWide = {opA, opA} >> shamt;

   // bit 0 of a lands in the msb
   assign reversed = {<<{opA}};

   // signed overflow
   // add overflows when like signs give an unlike sign
   assign addOfl = (opA[wordW-1] == opB[wordW-1]) && (addWide[wordW-1] != opA[wordW-1]);
   // b - a overflows when signs differ and the result leaves the sign of b
   assign subOfl = (opB[wordW-1] != opA[wordW-1]) && (subOut[wordW-1] != opB[wordW-1]);

   // base operations
   always_comb begin
      case (aluOp)
         execCtlPkg::ADD:  baseOut = addWide[wordW-1:0];
         execCtlPkg::SUB:  baseOut = subOut;
         execCtlPkg::XOR:  baseOut = opA ^ opB;
         execCtlPkg::ANDN: baseOut = opA & ~opB;
         execCtlPkg::ROL:  baseOut = rolWide[2*wordW-1:wordW];
         execCtlPkg::SLL:  baseOut = opA << shamt;
         execCtlPkg::ROR:  baseOut = rorWide[wordW-1:0];
         execCtlPkg::SRL:  baseOut = opA >> shamt;
         default:          baseOut = '0;
      endcase
   end

   // single compare bit for the set-type overrides
   always_comb begin
      case (setKind)
         execCtlPkg::SEQ: cmpBit = (opA == opB);
         execCtlPkg::SLT: cmpBit = ($signed(opA) < $signed(opB));
         execCtlPkg::SLE: cmpBit = ($signed(opA) <= $signed(opB));
         execCtlPkg::SCO: cmpBit = addWide[wordW];
         default:         cmpBit = 1'b0;
      endcase
   end

   // final result with the override applied
   always_comb begin
      case (setKind)
         execCtlPkg::NONE: aluResult = baseOut;
         execCtlPkg::SEQ,
         execCtlPkg::SLT,
         execCtlPkg::SLE,
         execCtlPkg::SCO:  aluResult = execDataPkg::word_t'(cmpBit);
         execCtlPkg::BTR:  aluResult = reversed;
         execCtlPkg::SLBI: aluResult = (opA << byteW) | execDataPkg::word_t'(immVal[byteW-1:0]);
         default:          aluResult = baseOut;
      endcase
   end

   // flags
   assign aluZero = (aluResult == '0);
   // overflow only means something for add and subtract
   assign aluOfl = (aluOp == execCtlPkg::ADD) ? addOfl :
                   (aluOp == execCtlPkg::SUB) ? subOfl : 1'b0;

   // compares and carry out may only ever produce 0 or 1
   always_comb begin
      if (setKind inside {execCtlPkg::SEQ, execCtlPkg::SLT, execCtlPkg::SLE, execCtlPkg::SCO}) begin
         setIsBit: assert final (aluResult[wordW-1:1] == '0)
            else $error("aluUnit: set result %h has upper bits", aluResult);
      end
   end

endmodule

//--- branchUnit.sv
// combinational branch condition and target unit, instantiated by executeStage beside aluUnit
`timescale 1ns/1ps

module branchUnit (
   input  execDataPkg::word_t  regData1,
   input  execDataPkg::word_t  immVal,
   input  execDataPkg::word_t  incPc,
   input  execCtlPkg::brCond_t brCond,
   input  execCtlPkg::pcSel_t  pcSel,
   output execDataPkg::word_t  brTarget,
   output logic                brTaken
);

   localparam int wordW = $bits(execDataPkg::word_t);

   execDataPkg::word_t targetBase;
   logic               regIsZero;
   logic               regIsNeg;

   // pc-relative branches and jumps add to the incremented pc
   // register jumps add to register 1
   assign targetBase = (pcSel == execCtlPkg::REG_REL) ? regData1 : incPc;

   // carry out is dropped, the address wraps
   assign brTarget = targetBase + immVal;

   // all conditions look at register 1 only
   assign regIsZero = (regData1 == '0);
   assign regIsNeg  = regData1[wordW-1];

   // condition select
   always_comb begin
      case (brCond)
         execCtlPkg::NEVER:  brTaken = 1'b0;
         execCtlPkg::BEQZ:   brTaken = regIsZero;
         execCtlPkg::BNEZ:   brTaken = !regIsZero;
         execCtlPkg::BLTZ:   brTaken = regIsNeg;
         // zero counts as non-negative
         execCtlPkg::BGEZ:   brTaken = !regIsNeg;
         // unconditional jumps
         execCtlPkg::ALWAYS: brTaken = 1'b1;
         default:            brTaken = 1'b0;
      endcase
   end

   // a plain alu instruction decodes to NEVER and must not redirect the pc
   always_comb begin
      if (brCond == execCtlPkg::NEVER) begin
         neverNotTaken: assert final (!brTaken)
            else $error("branchUnit: taken with condition NEVER");
      end
   end

endmodule

//--- resultMerge.sv
// output register of the execute stage, captures alu and branch results together on the input strobe
`timescale 1ns/1ps
`include "exec_config.svh"

module resultMerge (
   input  logic               clk,
   input  logic               rstN,
   input  logic               inValid,
   input  execDataPkg::word_t aluResult,
   input  execDataPkg::word_t brTarget,
   input  logic               aluZero,
   input  logic               aluOfl,
   input  logic               brTaken,
   output logic               outValid,
   output logic               zero,
   output logic               ofl,
   output logic               pcSrc,
   output execDataPkg::word_t result,
   output execDataPkg::word_t newPc
);

   // strobe and redirect
   // both drop in any cycle without an input strobe
   always_ff @(posedge clk) begin
      if (!rstN) begin
         outValid <= 1'b0;
         pcSrc    <= 1'b0;
      end else begin
         outValid <= inValid;
         pcSrc    <= inValid & brTaken;
      end
   end

   // record of the strobed item
   // held between strobes so the next stage sees stable data
   always_ff @(posedge clk) begin
      if (!rstN) begin
         result <= '0;
         newPc  <= '0;
         zero   <= 1'b0;
         ofl    <= 1'b0;
      end else if (inValid) begin
         result <= aluResult;
         zero   <= aluZero;
         ofl    <= aluOfl;
         // target is kept even when not taken, pcSrc decides its use
         newPc  <= brTarget;
      end
   end

   // every strobe comes out after the fixed latency
   strobeOut: assert property (@(posedge clk) disable iff (!rstN)
      inValid |-> ##`EXEC_LATENCY outValid)
      else $error("resultMerge: strobe lost");

   // idle input cycles give idle output cycles
   gapOut: assert property (@(posedge clk) disable iff (!rstN)
      !inValid |-> ##`EXEC_LATENCY !outValid)
      else $error("resultMerge: output strobe without input strobe");

   // a redirect always comes with a valid record
   pcSrcValid: assert property (@(posedge clk) disable iff (!rstN)
      pcSrc |-> outValid)
      else $error("resultMerge: pcSrc without outValid");

endmodule

//--- executeStage.sv
// top of the execute stage, fed by decode and read by the memory/writeback stage
`timescale 1ns/1ps

module executeStage (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 inValid,
   input  execDataPkg::word_t   regData1,
   input  execDataPkg::word_t   regData2,
   input  execDataPkg::word_t   immVal,
   input  execDataPkg::word_t   incPc,
   input  logic                 aluSrc,
   input  execCtlPkg::aluOp_t   aluOp,
   input  execCtlPkg::setKind_t setKind,
   input  execCtlPkg::brCond_t  brCond,
   input  execCtlPkg::pcSel_t   pcSel,
   output logic                 outValid,
   output execDataPkg::word_t   result,
   output logic                 zero,
   output logic                 ofl,
   output execDataPkg::word_t   newPc,
   output logic                 pcSrc
);

   // combinational results ahead of the output register
   execDataPkg::word_t aluResult;
   execDataPkg::word_t brTarget;
   logic               aluZero;
   logic               aluOfl;
   logic               brTaken;

   // datapath
   aluUnit u_alu (
      .regData1  (regData1),
      .regData2  (regData2),
      .immVal    (immVal),
      .aluSrc    (aluSrc),
      .aluOp     (aluOp),
      .setKind   (setKind),
      .aluResult (aluResult),
      .aluZero   (aluZero),
      .aluOfl    (aluOfl)
   );

   // runs on the same inputs in parallel with the alu
   branchUnit u_branch (
      .regData1 (regData1),
      .immVal   (immVal),
      .incPc    (incPc),
      .brCond   (brCond),
      .pcSel    (pcSel),
      .brTarget (brTarget),
      .brTaken  (brTaken)
   );

   // one-cycle output register
   resultMerge u_merge (
      .clk       (clk),
      .rstN      (rstN),
      .inValid   (inValid),
      .aluResult (aluResult),
      .brTarget  (brTarget),
      .aluZero   (aluZero),
      .aluOfl    (aluOfl),
      .brTaken   (brTaken),
      .outValid  (outValid),
      .zero      (zero),
      .ofl       (ofl),
      .pcSrc     (pcSrc),
      .result    (result),
      .newPc     (newPc)
   );

endmodule

//--- tbExecute.sv
// self-checking testbench for executeStage, built from filelist.f and run with the Makefile
`timescale 1ns/1ps
`include "exec_config.svh"

module tbExecute;

   localparam int wordW = `EXEC_WORD_W;
   localparam int resetCycles = 10;
   // strobes per test: alu ops, set compares, btr and slbi, branches, back to back
   localparam int totalStrobes = 64 + 24 + 12 + 36 + 40;
   localparam int cycleLimit = 2 * totalStrobes + resetCycles + 100;

   logic                 clk;
   logic                 rstN;
   logic                 inValid;
   execDataPkg::word_t   regData1;
   execDataPkg::word_t   regData2;
   execDataPkg::word_t   immVal;
   execDataPkg::word_t   incPc;
   logic                 aluSrc;
   execCtlPkg::aluOp_t   aluOp;
   execCtlPkg::setKind_t setKind;
   execCtlPkg::brCond_t  brCond;
   execCtlPkg::pcSel_t   pcSel;
   logic                 outValid;
   execDataPkg::word_t   result;
   logic                 zero;
   logic                 ofl;
   execDataPkg::word_t   newPc;
   logic                 pcSrc;

   // expected record of the last strobed item
   execDataPkg::word_t heldResult;
   execDataPkg::word_t heldPc;
   logic               heldZero;
   logic               heldOfl;
   logic               heldTaken;
   string              heldName;
   string              testName = "resetIdle";
   logic               seenStrobe;
   int                 inFlight;
   int                 cycleCount = 0;
   int                 errorCount = 0;
   int                 errorMark = 0;
   int                 passCount = 0;
   int                 failCount = 0;
   integer             seed;

   executeStage u_dut (
      .clk(clk), .rstN(rstN), .inValid(inValid),
      .regData1(regData1), .regData2(regData2), .immVal(immVal), .incPc(incPc),
      .aluSrc(aluSrc), .aluOp(aluOp), .setKind(setKind), .brCond(brCond), .pcSel(pcSel),
      .outValid(outValid), .result(result), .zero(zero), .ofl(ofl),
      .newPc(newPc), .pcSrc(pcSrc)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // base operation, count is the low nibble of b
   function automatic execDataPkg::word_t modelBase(execCtlPkg::aluOp_t op,
         execDataPkg::word_t a, execDataPkg::word_t b);
      int s;
      s = int'(b[3:0]);
      case (op)
         execCtlPkg::ADD:  return a + b;
         execCtlPkg::SUB:  return b - a;
         execCtlPkg::XOR:  return a ^ b;
         execCtlPkg::ANDN: return a & ~b;
         execCtlPkg::ROL:  return (a << s) | (a >> (wordW - s));
         execCtlPkg::SLL:  return a << s;
         execCtlPkg::ROR:  return (a >> s) | (a << (wordW - s));
         default:          return a >> s;
      endcase
   endfunction

   // result after the set-kind override
   function automatic execDataPkg::word_t modelResult(execCtlPkg::aluOp_t op,
         execCtlPkg::setKind_t k, execDataPkg::word_t a, execDataPkg::word_t b,
         execDataPkg::word_t imm);
      execDataPkg::word_t r;
      r = '0;
      case (k)
         execCtlPkg::SEQ: r[0] = (a == b);
         // signed compares done on sign-extended integers
         execCtlPkg::SLT: r[0] = (int'($signed(a)) < int'($signed(b)));
         execCtlPkg::SLE: r[0] = (int'($signed(a)) <= int'($signed(b)));
         // carry out seen as an unsigned sum past the word range
         execCtlPkg::SCO: r[0] = (int'(a) + int'(b) > 2**wordW - 1);
         execCtlPkg::BTR: begin
            for (int i = 0; i < wordW; i++) r[i] = a[wordW-1-i];
         end
         execCtlPkg::SLBI: r = {a[wordW-9:0], imm[7:0]};
         default: r = modelBase(op, a, b);
      endcase
      return r;
   endfunction

   // signed overflow from an integer sum out of range
   function automatic logic modelOfl(execCtlPkg::aluOp_t op, execDataPkg::word_t a,
         execDataPkg::word_t b);
      int v;
      if (op == execCtlPkg::ADD) v = int'($signed(a)) + int'($signed(b));
      else if (op == execCtlPkg::SUB) v = int'($signed(b)) - int'($signed(a));
      else return 1'b0;
      return (v > 2**(wordW-1) - 1) || (v < -(2**(wordW-1)));
   endfunction

   function automatic logic modelTaken(execCtlPkg::brCond_t c, execDataPkg::word_t r1);
      case (c)
         execCtlPkg::BEQZ:   return $signed(r1) == 0;
         execCtlPkg::BNEZ:   return $signed(r1) != 0;
         execCtlPkg::BLTZ:   return $signed(r1) < 0;
         execCtlPkg::BGEZ:   return $signed(r1) >= 0;
         execCtlPkg::ALWAYS: return 1'b1;
         default:            return 1'b0;
      endcase
   endfunction

   // store the model outputs for the item strobed at this edge
   always @(posedge clk) begin : captureExpected
      execDataPkg::word_t b;
      execDataPkg::word_t r;
      b = aluSrc ? immVal : regData2;
      r = modelResult(aluOp, setKind, regData1, b, immVal);
      if (!rstN) begin
         seenStrobe <= 1'b0;
         inFlight <= 0;
      end else begin
         if (inValid) begin
            seenStrobe <= 1'b1;
            heldName <= testName;
            heldResult <= r;
            heldZero <= (r == '0);
            heldOfl <= modelOfl(aluOp, regData1, b);
            heldTaken <= modelTaken(brCond, regData1);
            heldPc <= ((pcSel == execCtlPkg::REG_REL) ? regData1 : incPc) + immVal;
         end
         inFlight <= inFlight + int'(inValid) - int'(outValid);
      end
   end

   task automatic reportMismatch(string what, execDataPkg::word_t expVal,
         execDataPkg::word_t actVal);
      errorCount++;
      $display("MISMATCH %s %s expected %h actual %h", heldName, what, expVal, actVal);
   endtask

   task automatic reportFailure(string text);
      errorCount++;
      $display("%s: %s", testName, text);
   endtask

   // protocol at the rising edge
   latencyCheck: assert property (@(posedge clk) disable iff (!rstN)
      inValid |-> ##`EXEC_LATENCY outValid)
      else reportFailure("outValid did not follow a strobe after one cycle");
   gapCheck: assert property (@(posedge clk) disable iff (!rstN)
      !inValid |-> ##`EXEC_LATENCY (!outValid && !pcSrc))
      else reportFailure("output strobe or redirect without an input strobe");

   // data at the falling edge, where outputs and held values are stable
   resetCheck: assert property (@(negedge clk) disable iff (!rstN)
      !seenStrobe |-> (!outValid && !pcSrc && result == '0 && newPc == '0))
      else reportFailure("outputs not idle and zero after reset");
   resultCheck: assert property (@(negedge clk) disable iff (!rstN)
      outValid |-> result == heldResult) else reportMismatch("result", heldResult, result);
   zeroCheck: assert property (@(negedge clk) disable iff (!rstN)
      outValid |-> zero == heldZero) else reportMismatch("zero", heldZero, zero);
   oflCheck: assert property (@(negedge clk) disable iff (!rstN)
      outValid |-> ofl == heldOfl) else reportMismatch("ofl", heldOfl, ofl);
   pcSrcCheck: assert property (@(negedge clk) disable iff (!rstN)
      outValid |-> pcSrc == heldTaken) else reportMismatch("pcSrc", heldTaken, pcSrc);
   newPcCheck: assert property (@(negedge clk) disable iff (!rstN)
      outValid |-> newPc == heldPc) else reportMismatch("newPc", heldPc, newPc);
   qualCheck: assert property (@(negedge clk) disable iff (!rstN) !outValid |-> !pcSrc)
      else reportFailure("pcSrc high while outValid is low");

   // hard stop if a test never drains
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("timeout: run did not end within %0d cycles", cycleLimit);
         $display("Some tests failed");
         $finish;
      end
   end

   // corners: zero, most negative, all ones, count 15, then random
   function automatic execDataPkg::word_t cornerValue(int idx);
      case (idx)
         0: return '0;
         1: return {1'b1, {(wordW-1){1'b0}}};
         2: return '1;
         3: return execDataPkg::word_t'(15);
         default: return execDataPkg::word_t'($random(seed));
      endcase
   endfunction

   task automatic randomInputs();
      regData1 = execDataPkg::word_t'($random(seed));
      regData2 = execDataPkg::word_t'($random(seed));
      immVal = execDataPkg::word_t'($random(seed));
      incPc = execDataPkg::word_t'($random(seed));
      aluSrc = $random(seed) & 1;
      aluOp = execCtlPkg::aluOp_t'($random(seed) & 7);
      setKind = execCtlPkg::setKind_t'($unsigned($random(seed)) % 7);
      brCond = execCtlPkg::brCond_t'($unsigned($random(seed)) % 6);
      pcSel = execCtlPkg::pcSel_t'($random(seed) & 1);
   endtask

   // one strobe, then now and then an idle cycle
   task automatic sendItem(logic allowGap);
      inValid = 1'b1;
      @(posedge clk);
      #1;
      if (allowGap && (($random(seed) & 3) == 0)) begin
         inValid = 1'b0;
         @(posedge clk);
         #1;
      end
   endtask

   task automatic startTest(string name);
      testName = name;
      errorMark = errorCount;
   endtask

   // wait for the last output strobe, then report the test
   task automatic finishTest();
      int waited;
      waited = 0;
      inValid = 1'b0;
      while (inFlight != 0 && waited < 10) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (inFlight != 0) reportFailure("output strobe never arrived");
      if (errorCount == errorMark) passCount++;
      else failCount++;
      $display("test %s finished with %0d errors", testName, errorCount - errorMark);
   endtask

   initial begin
      execDataPkg::word_t pairA [6];
      execDataPkg::word_t pairB [6];
      seed = 32'h31d6b8da;
      // signed edge pairs for the compares
      pairA = '{16'h0000, 16'h8000, 16'h8000, 16'h0001, 16'hffff, 16'h7fff};
      pairB = '{16'h0000, 16'h0001, 16'h7fff, 16'h8000, 16'hffff, 16'h8000};
      rstN = 1'b0;
      inValid = 1'b0;
      regData1 = '0;
      regData2 = '0;
      immVal = '0;
      incPc = '0;
      aluSrc = 1'b0;
      aluOp = execCtlPkg::ADD;
      setKind = execCtlPkg::NONE;
      brCond = execCtlPkg::NEVER;
      pcSel = execCtlPkg::PC_REL;
      repeat (resetCycles) @(posedge clk);
      #1;
      rstN = 1'b1;
      // idle outputs before the first strobe
      startTest("resetIdle");
      repeat (3) begin
         @(posedge clk);
         #1;
      end
      finishTest();
      startTest("aluOps");
      for (int op = 0; op < 8; op++) begin
         for (int src = 0; src < 2; src++) begin
            for (int i = 0; i < 4; i++) begin
               randomInputs();
               aluOp = execCtlPkg::aluOp_t'(op);
               setKind = execCtlPkg::NONE;
               aluSrc = src[0];
               regData1 = cornerValue(i);
               regData2 = cornerValue((i + op) % 5);
               immVal = cornerValue((i + op + 2) % 5);
               sendItem(1'b1);
            end
         end
      end
      finishTest();
      startTest("setCompare");
      for (int k = 1; k < 5; k++) begin
         for (int i = 0; i < 6; i++) begin
            randomInputs();
            setKind = execCtlPkg::setKind_t'(k);
            regData1 = pairA[i];
            // same b from either source
            regData2 = pairB[i];
            immVal = pairB[i];
            sendItem(1'b1);
         end
      end
      finishTest();
      startTest("btrSlbi");
      for (int i = 0; i < 12; i++) begin
         randomInputs();
         setKind = (i < 6) ? execCtlPkg::BTR : execCtlPkg::SLBI;
         regData1 = cornerValue(i % 6);
         sendItem(1'b1);
      end
      finishTest();
      startTest("branches");
      for (int c = 0; c < 6; c++) begin
         for (int p = 0; p < 2; p++) begin
            for (int sgn = 0; sgn < 3; sgn++) begin
               randomInputs();
               brCond = execCtlPkg::brCond_t'(c);
               pcSel = execCtlPkg::pcSel_t'(p);
               // zero, negative, positive register 1
               if (sgn == 0) regData1 = '0;
               else if (sgn == 1) regData1 = regData1 | cornerValue(1);
               else regData1 = (regData1 & ~cornerValue(1)) | 16'h0001;
               sendItem(1'b1);
            end
         end
      end
      finishTest();
      // a burst with no gaps first, then mixed gaps
      startTest("backToBack");
      for (int i = 0; i < 40; i++) begin
         randomInputs();
         sendItem(i >= 20);
      end
      finishTest();
      $display("tests passed %0d, failed %0d, check errors %0d", passCount, failCount,
         errorCount);
      if (failCount == 0 && errorCount == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+.
execDataPkg.sv
execCtlPkg.sv
aluUnit.sv
branchUnit.sv
resultMerge.sv
executeStage.sv
tbExecute.sv

//--- Makefile
TOP = tbExecute

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal -f filelist.f --top-module $(TOP) -o simExecute

run: compile
	-./obj_dir/simExecute > run.log 2>&1
	@cat run.log
	@if grep -q "Some tests failed" run.log; then exit 1; fi
	@grep -q "All tests passed" run.log

clean:
	rm -rf obj_dir run.log
